// File: hw/drumMesh_consts.svh
`ifndef DRUM_MESH_CONSTS_SVH
`define DRUM_MESH_CONSTS_SVH

// Fixed-point format of every displacement and coefficient, Q1.17
`define DM_WIDTH 18
`define DM_FRAC 17

// Saturation limits of the signed sample range
`define DM_MAX ((1 <<< (`DM_WIDTH - 1)) - 1)
`define DM_MIN (-(1 <<< (`DM_WIDTH - 1)))

// Default mesh size in nodes
`define DM_XSIZE 4
`define DM_YSIZE 4

// Largest supported dimension, which sets the 3-bit coordinates
`define DM_MAXDIM 8
`define DM_COORDW 3

`endif

// File: hw/drumMeshPkg.sv
`default_nettype none

`include "drumMesh_consts.svh"

package drumMeshPkg;

  // Signed displacement, Q1.17
  typedef logic signed [`DM_WIDTH-1:0] sampleT;

  // Control states
  typedef enum logic [1:0] {
    stateIdle,
    stateLoad,
    stateRunning,
    statePaused
  } meshStateT;

  // Bell profile along one axis, peak of 0.5 in the middle
  localparam sampleT profileTable [0:`DM_MAXDIM-1] = '{
    18'sd0,
    18'sd19661,
    18'sd49807,
    18'sd65536,
    18'sd65536,
    18'sd49807,
    18'sd19661,
    18'sd0
  };

endpackage

`default_nettype wire

// File: hw/meshControl.sv
`timescale 1ns/10ps
`default_nettype none

module meshControl (
  input  logic                 allValid,
  input  logic                 rst,
  input  logic                 strike,
  input  logic                 run,
  input  drumMeshPkg::sampleT  rho,
  input  drumMeshPkg::sampleT  eta,
  input  logic [2:0]           tensionSel,
  output logic                 loadNode,
  output logic                 stepNode,
  output logic                 sampleStrobe,
  output drumMeshPkg::sampleT  rhoEff,
  output drumMeshPkg::sampleT  etaEff
);

  drumMeshPkg::meshStateT state;
  drumMeshPkg::meshStateT stateNext;

  // Next-state logic
  always_comb begin
    stateNext = state;
    case (state)
      drumMeshPkg::stateIdle: begin
        stateNext = drumMeshPkg::stateIdle;
      end
      drumMeshPkg::stateLoad: begin
        stateNext = run ? drumMeshPkg::stateRunning : drumMeshPkg::statePaused;
      end
      drumMeshPkg::stateRunning: begin
        if (!run) begin
          stateNext = drumMeshPkg::statePaused;
        end
      end
      drumMeshPkg::statePaused: begin
        if (run) begin
          stateNext = drumMeshPkg::stateRunning;
        end
      end
      default: begin
        stateNext = drumMeshPkg::stateIdle;
      end
    endcase
    // A strike restarts the note from any state
    if (strike) begin
      stateNext = drumMeshPkg::stateLoad;
    end
  end

  always_ff @(posedge allValid) begin
    if (rst) begin
      state <= drumMeshPkg::stateIdle;
    end else begin
      state <= stateNext;
    end
  end

  // Broadcast strobes to the nodes
  assign loadNode = (state == drumMeshPkg::stateLoad);
  assign stepNode = (state == drumMeshPkg::stateRunning);

  // One sample per load or step, one cycle behind the node update
  always_ff @(posedge allValid) begin
    if (rst) begin
      sampleStrobe <= 1'b0;
    end else begin
      sampleStrobe <= loadNode | stepNode;
    end
  end

  // Coefficients only change on a new note
  always_ff @(posedge allValid) begin
    if (rst) begin
      rhoEff <= '0;
      etaEff <= '0;
    end else if (strike) begin
      rhoEff <= rho >>> tensionSel;
      etaEff <= eta;
    end
  end

endmodule

`default_nettype wire

// File: hw/meshNode.sv
`timescale 1ns/10ps
`default_nettype none

`include "drumMesh_consts.svh"

module meshNode (
  input  logic                 allValid,
  input  logic                 rst,
  input  logic                 loadNode,
  input  logic                 stepNode,
  input  drumMeshPkg::sampleT  uInit,
  input  drumMeshPkg::sampleT  uNorth,
  input  drumMeshPkg::sampleT  uSouth,
  input  drumMeshPkg::sampleT  uWest,
  input  drumMeshPkg::sampleT  uEast,
  input  drumMeshPkg::sampleT  rhoEff,
  input  drumMeshPkg::sampleT  etaEff,
  output drumMeshPkg::sampleT  u
);

  // Wide enough for an 18 by 21 bit product plus the sums
  typedef logic signed [47:0] wideT;

  drumMeshPkg::sampleT uPrev;
  drumMeshPkg::sampleT uNext;

  wideT lap;
  wideT velocity;
  wideT rhoTerm;
  wideT etaTerm;
  wideT sumWide;

  // Discrete Laplacian over the four neighbours
  assign lap = wideT'(uNorth) + wideT'(uSouth) + wideT'(uWest) + wideT'(uEast)
             - (wideT'(u) <<< 2);

  // Velocity estimate for the damping term
  assign velocity = wideT'(u) - wideT'(uPrev);

  // Both products come back to Q1.17
  assign rhoTerm = (wideT'(rhoEff) * lap) >>> `DM_FRAC;
  assign etaTerm = (wideT'(etaEff) * velocity) >>> `DM_FRAC;

  assign sumWide = (wideT'(u) <<< 1) - wideT'(uPrev) + rhoTerm - etaTerm;

  // Clamp to the sample range
  always_comb begin
    if (sumWide > wideT'(`DM_MAX)) begin
      uNext = drumMeshPkg::sampleT'(`DM_MAX);
    end else if (sumWide < wideT'(`DM_MIN)) begin
      uNext = drumMeshPkg::sampleT'(`DM_MIN);
    end else begin
      uNext = sumWide[`DM_WIDTH-1:0];
    end
  end

  always_ff @(posedge allValid) begin
    if (rst) begin
      u     <= '0;
      uPrev <= '0;
    end else if (loadNode) begin
      // Mesh starts at rest in the strike shape
      u     <= uInit;
      uPrev <= uInit;
    end else if (stepNode) begin
      uPrev <= u;
      u     <= uNext;
    end
  end

endmodule

`default_nettype wire

// File: hw/strikeShape.sv
`timescale 1ns/10ps
`default_nettype none

`include "drumMesh_consts.svh"

module strikeShape #(
  parameter int xPos = 0,
  parameter int yPos = 0
) (
  output drumMeshPkg::sampleT uInit
);

  // Table index for each axis, kept inside the table
  localparam int xIdx = xPos % `DM_MAXDIM;
  localparam int yIdx = yPos % `DM_MAXDIM;

  logic signed [2*`DM_WIDTH-1:0] shapeProd;

  // Separable bell, profile(x) times profile(y)
  assign shapeProd = drumMeshPkg::profileTable[xIdx] * drumMeshPkg::profileTable[yIdx];

  // Back to Q1.17; the product of two halves never exceeds a quarter
  assign uInit = shapeProd[`DM_FRAC +: `DM_WIDTH];

endmodule

`default_nettype wire

// File: hw/meshPickup.sv
`timescale 1ns/10ps
`default_nettype none

`include "drumMesh_consts.svh"

module meshPickup #(
  parameter int xSize = `DM_XSIZE,
  parameter int ySize = `DM_YSIZE
) (
  input  logic                               allValid,
  input  logic                               rst,
  input  logic                               sampleStrobe,
  input  logic [xSize*ySize*`DM_WIDTH-1:0]   meshFlat,
  input  logic [`DM_COORDW-1:0]              pickX,
  input  logic [`DM_COORDW-1:0]              pickY,
  output drumMeshPkg::sampleT                sample,
  output logic                               sampleValid
);

  logic [`DM_COORDW-1:0] colSel;
  logic [`DM_COORDW-1:0] rowSel;
  drumMeshPkg::sampleT   nodeSel;

  // Coordinates past the edge read the last column or row
  assign colSel = (pickX >= xSize) ? `DM_COORDW'(xSize - 1) : pickX;
  assign rowSel = (pickY >= ySize) ? `DM_COORDW'(ySize - 1) : pickY;

  // Row-major node order
  assign nodeSel = meshFlat[(int'(rowSel) * xSize + int'(colSel)) * `DM_WIDTH +: `DM_WIDTH];

  always_ff @(posedge allValid) begin
    if (rst) begin
      sample      <= '0;
      sampleValid <= 1'b0;
    end else begin
      sampleValid <= sampleStrobe;
      if (sampleStrobe) begin
        sample <= nodeSel;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/drumMesh.sv
`timescale 1ns/10ps
`default_nettype none

`include "drumMesh_consts.svh"

module drumMesh #(
  parameter int xSize = `DM_XSIZE,
  parameter int ySize = `DM_YSIZE
) (
  input  logic                   allValid,
  input  logic                   rst,
  input  logic                   strike,
  input  logic                   run,
  input  drumMeshPkg::sampleT    rho,
  input  drumMeshPkg::sampleT    eta,
  input  logic [2:0]             tensionSel,
  input  logic [`DM_COORDW-1:0]  pickX,
  input  logic [`DM_COORDW-1:0]  pickY,
  output drumMeshPkg::sampleT    sample,
  output logic                   sampleValid
);

  logic                loadNode;
  logic                stepNode;
  logic                sampleStrobe;
  drumMeshPkg::sampleT rhoEff;
  drumMeshPkg::sampleT etaEff;

  drumMeshPkg::sampleT meshU [0:ySize-1][0:xSize-1];
  wire [xSize*ySize*`DM_WIDTH-1:0] meshFlat;

  meshControl control (
    .allValid     (allValid),
    .rst          (rst),
    .strike       (strike),
    .run          (run),
    .rho          (rho),
    .eta          (eta),
    .tensionSel   (tensionSel),
    .loadNode     (loadNode),
    .stepNode     (stepNode),
    .sampleStrobe (sampleStrobe),
    .rhoEff       (rhoEff),
    .etaEff       (etaEff)
  );

  for (genvar y = 0; y < ySize; y++) begin : gRow
    for (genvar x = 0; x < xSize; x++) begin : gCol
      drumMeshPkg::sampleT uNorth;
      drumMeshPkg::sampleT uSouth;
      drumMeshPkg::sampleT uWest;
      drumMeshPkg::sampleT uEast;
      drumMeshPkg::sampleT uInit;

      // North and west edges are clamped to zero
      if (y > 0) begin : gNorth
        assign uNorth = meshU[y-1][x];
      end else begin : gNorthEdge
        assign uNorth = '0;
      end
      if (x > 0) begin : gWest
        assign uWest = meshU[y][x-1];
      end else begin : gWestEdge
        assign uWest = '0;
      end

      // South and east edges mirror the node itself
      if (y < ySize - 1) begin : gSouth
        assign uSouth = meshU[y+1][x];
      end else begin : gSouthEdge
        assign uSouth = meshU[y][x];
      end
      if (x < xSize - 1) begin : gEast
        assign uEast = meshU[y][x+1];
      end else begin : gEastEdge
        assign uEast = meshU[y][x];
      end

      strikeShape #(.xPos(x), .yPos(y)) shape (
        .uInit (uInit)
      );

      meshNode node (
        .allValid (allValid),
        .rst      (rst),
        .loadNode (loadNode),
        .stepNode (stepNode),
        .uInit    (uInit),
        .uNorth   (uNorth),
        .uSouth   (uSouth),
        .uWest    (uWest),
        .uEast    (uEast),
        .rhoEff   (rhoEff),
        .etaEff   (etaEff),
        .u        (meshU[y][x])
      );

      assign meshFlat[(y*xSize + x)*`DM_WIDTH +: `DM_WIDTH] = meshU[y][x];
    end
  end

  meshPickup #(.xSize(xSize), .ySize(ySize)) pickup (
    .allValid     (allValid),
    .rst          (rst),
    .sampleStrobe (sampleStrobe),
    .meshFlat     (meshFlat),
    .pickX        (pickX),
    .pickY        (pickY),
    .sample       (sample),
    .sampleValid  (sampleValid)
  );

endmodule

`default_nettype wire

// File: verif/drumMeshTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "drumMesh_consts.svh"

module drumMeshTb;

  localparam int xSize = `DM_XSIZE;
  localparam int ySize = `DM_YSIZE;
  localparam int sampleTimeout = 40;
  // Bell profile in Q1.17, peak 0.5 in the middle
  localparam longint profile [0:7] = '{0, 19661, 49807, 65536, 65536, 49807, 19661, 0};

  logic                  allValid;
  logic                  rst;
  logic                  strike;
  logic                  run;
  drumMeshPkg::sampleT   rho;
  drumMeshPkg::sampleT   eta;
  logic [2:0]            tensionSel;
  logic [`DM_COORDW-1:0] pickX;
  logic [`DM_COORDW-1:0] pickY;
  drumMeshPkg::sampleT   sample;
  logic                  sampleValid;

  // Reference mesh and its latched coefficients
  longint modelU [0:ySize-1][0:xSize-1];
  longint modelPrev [0:ySize-1][0:xSize-1];
  longint modelRho;
  longint modelEta;
  logic [31:0] lfsrState;

  drumMesh #(.xSize(xSize), .ySize(ySize)) DUT (.*);

  initial begin
    allValid = 1'b0;
    forever #5 allValid = ~allValid;
  end

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic longint clampSample(input longint v);
    if (v > `DM_MAX) return `DM_MAX;
    if (v < `DM_MIN) return `DM_MIN;
    return v;
  endfunction

  // Strike shape, mesh at rest, coefficients taken as the DUT latches them
  task automatic modelLoad();
    for (int y = 0; y < ySize; y++) begin
      for (int x = 0; x < xSize; x++) begin
        modelU[y][x] = (profile[x] * profile[y]) >>> `DM_FRAC;
        modelPrev[y][x] = modelU[y][x];
      end
    end
    modelRho = longint'(rho) >>> tensionSel;
    modelEta = longint'(eta);
  endtask

  task automatic modelStep();
    longint nextU [0:ySize-1][0:xSize-1];
    longint north;
    longint south;
    longint west;
    longint east;
    longint lap;
    longint rhoTerm;
    longint etaTerm;
    for (int y = 0; y < ySize; y++) begin
      for (int x = 0; x < xSize; x++) begin
        // Zero beyond north and west, own value beyond south and east
        north = (y > 0) ? modelU[y-1][x] : 0;
        west = (x > 0) ? modelU[y][x-1] : 0;
        south = (y < ySize - 1) ? modelU[y+1][x] : modelU[y][x];
        east = (x < xSize - 1) ? modelU[y][x+1] : modelU[y][x];
        lap = north + south + west + east - 4 * modelU[y][x];
        rhoTerm = (modelRho * lap) >>> `DM_FRAC;
        etaTerm = (modelEta * (modelU[y][x] - modelPrev[y][x])) >>> `DM_FRAC;
        nextU[y][x] = clampSample(2 * modelU[y][x] - modelPrev[y][x] + rhoTerm - etaTerm);
      end
    end
    modelPrev = modelU;
    modelU = nextU;
  endtask

  function automatic longint modelPick();
    int col;
    int row;
    col = (int'(pickX) >= xSize) ? xSize - 1 : int'(pickX);
    row = (int'(pickY) >= ySize) ? ySize - 1 : int'(pickY);
    return modelU[row][col];
  endfunction

  task automatic checkValue(input string name, input longint got, input longint expected);
    if (got != expected) begin
      $display("ERR time=%0t %s got=%0d expected=%0d", $time, name, got, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic waitSample();
    int cycles;
    cycles = 0;
    @(negedge allValid);
    while (!sampleValid && cycles < sampleTimeout) begin
      @(negedge allValid);
      cycles++;
    end
    if (!sampleValid) begin
      $display("No sampleValid pulse arrived within %0d cycles (time %0t)", sampleTimeout, $time);
      $display("SOME TESTS FAILED");
      $fatal(1, "Timeout while waiting for a sample");
    end
  endtask

  task automatic expectQuiet(input int cycles);
    repeat (cycles) begin
      @(negedge allValid);
      checkValue("sampleValid", sampleValid, 0);
    end
  endtask

  task automatic strikeNote();
    @(posedge allValid);
    strike <= 1'b1;
    @(posedge allValid);
    strike <= 1'b0;
    modelLoad();
  endtask

  // Strike while paused, check the loaded shape, then start stepping
  task automatic startNote();
    strikeNote();
    waitSample();
    checkValue("sample", sample, modelPick());
    @(posedge allValid);
    run <= 1'b1;
  endtask

  task automatic checkSteps(input int count);
    repeat (count) begin
      waitSample();
      modelStep();
      checkValue("sample", sample, modelPick());
    end
  endtask

  // Steps already in flight when run drops still come out
  task automatic pauseAndDrain();
    @(posedge allValid);
    run <= 1'b0;
    repeat (8) begin
      @(negedge allValid);
      if (sampleValid) begin
        modelStep();
        checkValue("sample", sample, modelPick());
      end
    end
  endtask

  task automatic randomPick();
    logic [31:0] r;
    r = randomBits(6);
    @(posedge allValid);
    pickX <= r[2:0];
    pickY <= r[5:3];
  endtask

  task automatic testReset();
    repeat (10) begin
      @(negedge allValid);
      checkValue("sampleValid", sampleValid, 0);
      checkValue("sample", sample, 0);
    end
  endtask

  task automatic testStrikeShape();
    for (int i = 0; i < 6; i++) begin
      if (i == 0) begin
        // Far corner, clamps to the last node
        @(posedge allValid);
        pickX <= 3'd7;
        pickY <= 3'd7;
      end else begin
        randomPick();
      end
      strikeNote();
      waitSample();
      checkValue("sample", sample, modelPick());
      expectQuiet(6);
    end
  endtask

  task automatic testUndamped();
    logic [31:0] r;
    r = randomBits(16);
    randomPick();
    rho <= drumMeshPkg::sampleT'(r[15:0]);
    eta <= '0;
    tensionSel <= 3'd0;
    startNote();
    checkSteps(40);
    pauseAndDrain();
  endtask

  task automatic testDampedTension();
    logic [31:0] r;
    logic [2:0] shift;
    r = randomBits(31);
    shift = (r[30:28] == 3'd0) ? 3'd1 : r[30:28];
    randomPick();
    rho <= drumMeshPkg::sampleT'(r[15:0]);
    eta <= drumMeshPkg::sampleT'(r[27:16]) + 18'sd1;
    tensionSel <= shift;
    startNote();
    checkSteps(40);
    // New coefficients wait for the next strike
    r = randomBits(19);
    @(posedge allValid);
    rho <= drumMeshPkg::sampleT'(r[15:0]);
    tensionSel <= r[18:16];
    checkSteps(20);
  endtask

  task automatic testPauseResume();
    pauseAndDrain();
    expectQuiet(12);
    @(posedge allValid);
    run <= 1'b1;
    checkSteps(20);
    pauseAndDrain();
  endtask

  task automatic testSaturation();
    logic hitLimit;
    hitLimit = 1'b0;
    randomPick();
    rho <= drumMeshPkg::sampleT'(`DM_MAX);
    eta <= '0;
    tensionSel <= 3'd0;
    startNote();
    repeat (40) begin
      checkSteps(1);
      // The unstable mesh must drive the pickup into the clamp
      if (sample == `DM_MAX || sample == `DM_MIN) begin
        hitLimit = 1'b1;
      end
    end
    checkValue("saturated sample seen", hitLimit, 1);
    pauseAndDrain();
  endtask

  initial begin
    rst = 1'b1;
    strike = 1'b0;
    run = 1'b0;
    rho = '0;
    eta = '0;
    tensionSel = '0;
    pickX = '0;
    pickY = '0;
    lfsrState = 32'h1896;
    repeat (5) @(posedge allValid);
    rst <= 1'b0;
    testReset();
    testStrikeShape();
    testUndamped();
    testDampedTension();
    testPauseResume();
    testSaturation();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hw
hw/drumMeshPkg.sv
hw/meshControl.sv
hw/meshNode.sv
hw/strikeShape.sv
hw/meshPickup.sv
hw/drumMesh.sv
verif/drumMeshTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = drumMeshTb
FILELIST = compile.f
BUILDDIR = obj_dir
LOG      = sim.log
PASS_MSG = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)
